// File: Makefile
# Verilator build and run for the revo testbench

VERILATOR ?= verilator
TOP ?= revo_tb
FILELIST ?= revo.f
OBJ_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
SIM ?= $(OBJ_DIR)/V$(TOP)

SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: $(SIM)
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: revo.f
+incdir+.
revo_pkg.sv
revo_phase_if.sv
revo_edge_detect.sv
revo_phase_finder.sv
revo_trigger_encoder.sv
revo_activity_monitor.sv
revo_top.sv
revo_assert.sv
revo_tb.sv

// File: revo_activity_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "revo_consts.svh"

module revo_activity_monitor (
	input logic clock127,
	input logic pll_127_127_locked,
	revo_phase_if.monitor phase,
	input logic trg,
	output logic revo_active
);

	localparam int count_bits = $clog2(`REVO_WINDOW_CYCLES);
	localparam logic [count_bits-1:0] last_count = count_bits'(`REVO_WINDOW_CYCLES - 1);

	logic [count_bits-1:0] window_count;
	// Sticky within the current window
	logic trg_seen;
	logic window_end;

	assign window_end = (window_count == last_count);

	always_ff @(posedge clock127 or negedge pll_127_127_locked) begin
		if (!pll_127_127_locked) begin
			window_count <= '0;
			trg_seen <= 1'b0;
			revo_active <= 1'b0;
		end else begin
			if (window_end) begin
				window_count <= '0;
				// Result of the closing window, last cycle included
				revo_active <= trg_seen | (phase.running & trg);
				trg_seen <= 1'b0;
			end else begin
				window_count <= window_count + 1'b1;
				trg_seen <= trg_seen | (phase.running & trg);
			end
		end
	end

endmodule

`default_nettype wire

// File: revo_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "revo_consts.svh"

module revo_assert (
	input logic clock127,
	input logic pll_127_127_locked,
	input logic [1:0] phase_sel,
	input logic phase_locked,
	input logic running,
	input logic trg,
	input logic [1:0] trg_pair
);

	// ------------------------------------------------------------
	// Trigger shape
	// ------------------------------------------------------------
	trg_single: assert property (
		@(posedge clock127) disable iff (!pll_127_127_locked)
		trg |=> !trg
	) else $error("trg high in two consecutive cycles");

	// Held-high pair follows a trigger by one cycle
	mark_after_trg: assert property (
		@(posedge clock127) disable iff (!pll_127_127_locked)
		(trg_pair == `REVO_PAIR_MARK) |-> $past(trg)
	) else $error("trg_pair marked without a trigger in the previous cycle");

	// ------------------------------------------------------------
	// Phase status
	// ------------------------------------------------------------

	// Release comes at least one cycle after lock
	run_needs_lock: assert property (
		@(posedge clock127) disable iff (!pll_127_127_locked)
		running |-> (phase_locked && $past(phase_locked))
	) else $error("running high without phase_locked in this and the previous cycle");

	sel_frozen: assert property (
		@(posedge clock127) disable iff (!pll_127_127_locked)
		(phase_locked && $past(phase_locked)) |-> (phase_sel == $past(phase_sel))
	) else $error("phase_sel changed while locked");

endmodule

bind revo_top revo_assert revo_assert_i (
	.clock127(clock127),
	.pll_127_127_locked(pll_127_127_locked),
	.phase_sel(phase_sel),
	.phase_locked(phase_locked),
	.running(running),
	.trg(trg),
	.trg_pair(trg_pair)
);

`default_nettype wire

// File: revo_consts.svh
`ifndef REVO_CONSTS_SVH
`define REVO_CONSTS_SVH

// ------------------------------------------------------------
// Marker sampling
// ------------------------------------------------------------

// Samples of the revolution marker per clock127 cycle
`define REVO_OVERSAMPLE 4

// Activity window length in clock127 cycles
`define REVO_WINDOW_CYCLES 256

// ------------------------------------------------------------
// DDR bit pairs, {second half, first half}
// ------------------------------------------------------------
`define REVO_PAIR_IDLE 2'b00
`define REVO_PAIR_CLOCK 2'b01
// High half held across the whole cycle marks a trigger
`define REVO_PAIR_MARK 2'b11

`endif

// File: revo_edge_detect.sv
`timescale 1ns/1ps
`default_nettype none

module revo_edge_detect (
	input logic clock127,
	input logic pll_127_127_locked,
	input revo_pkg::revo_word_t revo_word,
	revo_phase_if.edger phase
);
	import revo_pkg::*;

	// Word seen on the previous edge
	revo_word_t prev_word;

	// A bit rose where it is set now and was clear one word earlier.
	// Each sample position is compared with itself, not with its neighbour
	always_ff @(posedge clock127 or negedge pll_127_127_locked) begin
		if (!pll_127_127_locked) begin
			prev_word <= '0;
			phase.pulse_word <= '0;
		end else begin
			prev_word <= revo_word;
			phase.pulse_word <= revo_word & ~prev_word;
		end
	end

endmodule

`default_nettype wire

// File: revo_phase_finder.sv
`timescale 1ns/1ps
`default_nettype none

module revo_phase_finder (
	input logic clock127,
	input logic pll_127_127_locked,
	revo_phase_if.finder phase
);
	import revo_pkg::*;

	finder_state_t state;
	phase_sel_t sel;

	// ------------------------------------------------------------
	// State machine
	// ------------------------------------------------------------
	always_ff @(posedge clock127 or negedge pll_127_127_locked) begin
		if (!pll_127_127_locked) begin
			state <= finder_hunting;
			sel <= '0;
		end else begin
			case (state)
				finder_hunting: begin
					// First recognised pattern decides the phase
					case (phase.pulse_word)
						4'b1111: begin
							sel <= 2'd3;
							state <= finder_settling;
						end
						4'b1110: begin
							sel <= 2'd0;
							state <= finder_settling;
						end
						4'b1100: begin
							sel <= 2'd1;
							state <= finder_settling;
						end
						4'b1000: begin
							sel <= 2'd2;
							state <= finder_settling;
						end
						default: begin
							// Partial or odd patterns are skipped
							state <= finder_hunting;
						end
					endcase
				end
				finder_settling: begin
					state <= finder_running;
				end
				finder_running: begin
					// Select stays frozen until the next reset
					state <= finder_running;
				end
				default: begin
					state <= finder_hunting;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// Status towards the other stages
	// ------------------------------------------------------------
	assign phase.phase_sel = sel;

	// Locked from the settling cycle on
	assign phase.phase_locked = (state != finder_hunting);

	// Release one cycle after lock
	assign phase.running = (state == finder_running);

endmodule

`default_nettype wire

// File: revo_phase_if.sv
`timescale 1ns/1ps
`default_nettype none

interface revo_phase_if;
	import revo_pkg::*;

	// Per-bit rising edges of the marker word
	revo_word_t pulse_word;
	// Chosen clock phase and its status
	phase_sel_t phase_sel;
	logic phase_locked;
	logic running;

	// Edge detector output side
	modport edger (
		output pulse_word
	);

	modport finder (
		input pulse_word,
		output phase_sel,
		output phase_locked,
		output running
	);

	modport shaper (
		input pulse_word,
		input running
	);

	modport monitor (
		input running
	);

endinterface

`default_nettype wire

// File: revo_pkg.sv
`default_nettype none

`include "revo_consts.svh"

package revo_pkg;

	// One oversampled marker word, bit 3 is the earliest sample
	typedef logic [`REVO_OVERSAMPLE-1:0] revo_word_t;

	// Which of the four quarter-cycle clock phases is used
	typedef logic [1:0] phase_sel_t;

	// Phase finder progress
	typedef enum logic [1:0] {
		// No edge pattern recognised yet
		finder_hunting = 2'd0,
		// Pattern latched, one cycle before release
		finder_settling = 2'd1,
		// Downstream stages enabled
		finder_running = 2'd2
	} finder_state_t;

endpackage

`default_nettype wire

// File: revo_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "revo_consts.svh"

module revo_tb;
	import revo_pkg::*;

	localparam int reset_cycles = 8;
	localparam int window = `REVO_WINDOW_CYCLES;
	// Traffic and waiting fill a little over four windows
	localparam int cycle_limit = 6 * window + 200;
	localparam revo_word_t odd_patterns [10] = '{4'b0001, 4'b0011, 4'b0111, 4'b0101,
		4'b1010, 4'b0110, 4'b1001, 4'b1101, 4'b1011, 4'b0100};

	logic clock127 = 1'b0;
	logic pll_127_127_locked;
	revo_word_t revo_word;
	phase_sel_t phase_sel;
	logic phase_locked;
	logic running;
	logic trg;
	logic [1:0] clock_pair;
	logic [1:0] trg_pair;
	logic revo_active;

	int cycle_count = 0;
	int trg_total = 0;
	int edges;
	int trg_before;
	logic [31:0] rng_state = 32'h1dc0_2dbf;

	// Expected state after the latest rising edge
	revo_word_t exp_prev;
	revo_word_t exp_pulse;
	phase_sel_t exp_sel;
	logic exp_locked;
	logic exp_running;
	logic exp_marker;
	logic exp_marker_d;
	logic exp_trg;
	logic exp_hold;
	int exp_count;
	logic exp_seen;
	logic exp_active;

	revo_top revo_top_i (
		.clock127(clock127),
		.pll_127_127_locked(pll_127_127_locked),
		.revo_word(revo_word),
		.phase_sel(phase_sel),
		.phase_locked(phase_locked),
		.running(running),
		.trg(trg),
		.clock_pair(clock_pair),
		.trg_pair(trg_pair),
		.revo_active(revo_active)
	);

	always #10 clock127 = ~clock127;

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------

	// Expected select for a pulse word, -1 when nothing matches
	function automatic int ref_phase_sel(input revo_word_t pulse);
		case (pulse)
			4'b1111: return 3;
			4'b1110: return 0;
			4'b1100: return 1;
			4'b1000: return 2;
			default: return -1;
		endcase
	endfunction

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [1:0] expected_trg_pair(input logic run, input logic hold);
		if (!run) begin
			return `REVO_PAIR_IDLE;
		end
		return hold ? `REVO_PAIR_MARK : `REVO_PAIR_CLOCK;
	endfunction

	task automatic clear_model();
		exp_prev = '0;
		exp_pulse = '0;
		exp_sel = '0;
		exp_locked = 1'b0;
		exp_running = 1'b0;
		exp_marker = 1'b0;
		exp_marker_d = 1'b0;
		exp_trg = 1'b0;
		exp_hold = 1'b0;
		exp_count = 0;
		exp_seen = 1'b0;
		exp_active = 1'b0;
	endtask

	// One rising edge with the given input word
	task automatic advance_model(input revo_word_t word);
		int match;
		logic run_now;
		match = ref_phase_sel(exp_pulse);
		run_now = exp_running;
		if (exp_count == window - 1) begin
			exp_active = exp_seen | exp_trg;
			exp_seen = 1'b0;
			exp_count = 0;
		end else begin
			exp_seen = exp_seen | exp_trg;
			exp_count++;
		end
		if (run_now) begin
			exp_hold = exp_trg;
			exp_trg = exp_marker & ~exp_marker_d;
			exp_marker_d = exp_marker;
			exp_marker = |exp_pulse;
		end else begin
			exp_hold = 1'b0;
			exp_trg = 1'b0;
			exp_marker_d = 1'b0;
			exp_marker = 1'b0;
		end
		// Release follows lock by one cycle
		exp_running = exp_locked;
		if (!exp_locked && match >= 0) begin
			exp_locked = 1'b1;
			exp_sel = phase_sel_t'(match);
		end
		exp_pulse = word & ~exp_prev;
		exp_prev = word;
	endtask

	// ------------------------------------------------------------
	// Checking
	// ------------------------------------------------------------
	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s expected 0x%h actual 0x%h at %0t",
				name, expected, actual, $time);
			abort_run();
		end
	endtask

	function automatic logic watched_level(input string name);
		if (name == "phase_locked") begin
			return phase_locked;
		end else if (name == "running") begin
			return running;
		end else if (name == "trg") begin
			return trg;
		end
		return revo_active;
	endfunction

	// Counts rising edges until an output reaches the wanted level
	task automatic wait_level(input string name, input logic level, input int limit,
			output int count);
		count = 0;
		do begin
			@(posedge clock127);
			count++;
			@(negedge clock127);
		end while (watched_level(name) !== level && count < limit);
		if (watched_level(name) !== level) begin
			$display("%s did not reach %0d within %0d cycles", name, level, limit);
			abort_run();
		end
	endtask

	// Outputs settle well before the falling edge
	initial begin
		clear_model();
		@(posedge clock127);
		forever begin
			@(negedge clock127);
			if (!pll_127_127_locked) begin
				clear_model();
			end
			check_value("phase_sel", exp_sel, phase_sel);
			check_value("phase_locked", exp_locked, phase_locked);
			check_value("running", exp_running, running);
			check_value("trg", exp_trg, trg);
			check_value("clock_pair",
				exp_running ? `REVO_PAIR_CLOCK : `REVO_PAIR_IDLE, clock_pair);
			check_value("trg_pair", expected_trg_pair(exp_running, exp_hold), trg_pair);
			check_value("revo_active", exp_active, revo_active);
			if (trg) begin
				trg_total++;
			end
			if (pll_127_127_locked) begin
				advance_model(revo_word);
			end
		end
	end

	always @(posedge clock127) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			abort_run();
		end
	end

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	task automatic drive_word(input revo_word_t w);
		@(posedge clock127);
		revo_word <= w;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) drive_word('0);
	endtask

	task automatic lock_on(input revo_word_t w, input phase_sel_t sel);
		int count;
		drive_word(w);
		wait_level("phase_locked", 1'b1, 6, count);
		check_value("phase_locked latency", 2, count);
		check_value("phase_sel", sel, phase_sel);
		wait_level("running", 1'b1, 4, count);
		check_value("running latency", 1, count);
		idle_cycles(2);
	endtask

	task automatic send_random_trigger();
		revo_word_t w;
		int gap;
		int count;
		rng_state = next_random(rng_state);
		w = rng_state[3:0];
		if (w == '0) begin
			w = 4'b0100;
		end
		gap = 4 + int'(rng_state[10:8]);
		drive_word(w);
		wait_level("trg", 1'b1, 8, count);
		check_value("trg latency", 3, count);
		idle_cycles(gap);
	endtask

	initial begin
		pll_127_127_locked <= 1'b0;
		revo_word <= '0;
		repeat (reset_cycles) @(posedge clock127);
		pll_127_127_locked <= 1'b1;
		idle_cycles(3);

		// Patterns outside the table leave the finder hunting
		for (int i = 0; i < 10; i++) begin
			drive_word(odd_patterns[i]);
			drive_word('0);
		end
		@(negedge clock127);
		check_value("phase_locked", 0, phase_locked);
		lock_on(4'b1100, 2'd1);

		repeat (10) send_random_trigger();
		@(negedge clock127);
		check_value("phase_sel", 1, phase_sel);

		// Bursts of rising words
		trg_before = trg_total;
		drive_word(4'b0001);
		drive_word(4'b0011);
		drive_word(4'b0111);
		drive_word(4'b1111);
		idle_cycles(8);
		check_value("trg count", trg_before + 1, trg_total);
		drive_word(4'b1000);
		drive_word(4'b1100);
		drive_word(4'b1110);
		drive_word(4'b1111);
		idle_cycles(8);
		check_value("trg count", trg_before + 2, trg_total);

		// Activity windows
		wait_level("revo_active", 1'b1, window + 4, edges);
		wait_level("revo_active", 1'b0, 2 * window + 4, edges);
		send_random_trigger();
		wait_level("revo_active", 1'b1, window + 8, edges);
		wait_level("revo_active", 1'b0, window + 8, edges);

		// Reset in the middle of a run
		@(posedge clock127);
		pll_127_127_locked <= 1'b0;
		repeat (reset_cycles) @(posedge clock127);
		pll_127_127_locked <= 1'b1;
		idle_cycles(2);
		drive_word(4'b0110);
		drive_word('0);
		lock_on(4'b1111, 2'd3);
		send_random_trigger();
		idle_cycles(4);

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: revo_top.sv
`timescale 1ns/1ps
`default_nettype none

module revo_top (
	input logic clock127,
	input logic pll_127_127_locked,
	input revo_pkg::revo_word_t revo_word,
	output revo_pkg::phase_sel_t phase_sel,
	output logic phase_locked,
	output logic running,
	output logic trg,
	output logic [1:0] clock_pair,
	output logic [1:0] trg_pair,
	output logic revo_active
);

	revo_phase_if phase_bus ();

	// ------------------------------------------------------------
	// Marker path
	// ------------------------------------------------------------
	revo_edge_detect revo_edge_detect_i (
		.clock127(clock127),
		.pll_127_127_locked(pll_127_127_locked),
		.revo_word(revo_word),
		.phase(phase_bus.edger)
	);

	revo_phase_finder revo_phase_finder_i (
		.clock127(clock127),
		.pll_127_127_locked(pll_127_127_locked),
		.phase(phase_bus.finder)
	);

	revo_trigger_encoder revo_trigger_encoder_i (
		.clock127(clock127),
		.pll_127_127_locked(pll_127_127_locked),
		.phase(phase_bus.shaper),
		.trg(trg),
		.clock_pair(clock_pair),
		.trg_pair(trg_pair)
	);

	// Marker seen recently
	revo_activity_monitor revo_activity_monitor_i (
		.clock127(clock127),
		.pll_127_127_locked(pll_127_127_locked),
		.phase(phase_bus.monitor),
		.trg(trg),
		.revo_active(revo_active)
	);

	// Status straight from the bus
	assign phase_sel = phase_bus.phase_sel;
	assign phase_locked = phase_bus.phase_locked;
	assign running = phase_bus.running;

endmodule

`default_nettype wire

// File: revo_trigger_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "revo_consts.svh"

module revo_trigger_encoder (
	input logic clock127,
	input logic pll_127_127_locked,
	revo_phase_if.shaper phase,
	output logic trg,
	output logic [1:0] clock_pair,
	output logic [1:0] trg_pair
);

	// Marker level and its copy one cycle later
	logic marker;
	logic marker_d;
	// Set in the cycle after trg, drives the held-high pair
	logic mark_hold;

	// ------------------------------------------------------------
	// Marker level to one-cycle trigger
	// ------------------------------------------------------------
	always_ff @(posedge clock127 or negedge pll_127_127_locked) begin
		if (!pll_127_127_locked) begin
			marker <= 1'b0;
			marker_d <= 1'b0;
			trg <= 1'b0;
			mark_hold <= 1'b0;
		end else if (!phase.running) begin
			// Nothing passes before the phase is settled
			marker <= 1'b0;
			marker_d <= 1'b0;
			trg <= 1'b0;
			mark_hold <= 1'b0;
		end else begin
			marker <= |phase.pulse_word;
			marker_d <= marker;
			// Only the rising edge of the level counts,
			// so a burst of rising words gives one trigger
			trg <= marker & ~marker_d;
			mark_hold <= trg;
		end
	end

	// ------------------------------------------------------------
	// DDR bit pairs
	// ------------------------------------------------------------

	// Plain forwarded clock
	assign clock_pair = phase.running ? `REVO_PAIR_CLOCK : `REVO_PAIR_IDLE;

	// Clock with the trigger cycle stretched high
	always_comb begin
		if (!phase.running) begin
			trg_pair = `REVO_PAIR_IDLE;
		end else if (mark_hold) begin
			trg_pair = `REVO_PAIR_MARK;
		end else begin
			trg_pair = `REVO_PAIR_CLOCK;
		end
	end

endmodule

`default_nettype wire
